/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // instruction and data widths
    localparam int LEN_INST = 32;
    localparam int LEN_WORD = 32;

    // line geometry, two words per line
    localparam int LOG_FETCH_PARA = 1;
    localparam int FETCH_PARA = 2 ** LOG_FETCH_PARA;
    localparam int LEN_MEMISTR_ADDR = 10;

    // lowest pc bit of the line address
    localparam int LINE_LSB = LOG_FETCH_PARA + 2;

    // prefetch window
    localparam int PREDICT_SIZE = 5;
    localparam int NUM_PROBE = PREDICT_SIZE + 1;

    // cache size
    localparam int LOG_CACHE_DEPTH = 3;
    localparam int CACHE_DEPTH = 2 ** LOG_CACHE_DEPTH;

    typedef logic [LEN_MEMISTR_ADDR-1:0] line_addr_t;
    typedef logic [LEN_INST-1:0] inst_t;
    typedef logic [LEN_WORD-1:0] word_t;
    typedef logic [LEN_INST*FETCH_PARA-1:0] cache_line_t;
    typedef logic [FETCH_PARA-1:0] wen_t;
    typedef logic [LOG_CACHE_DEPTH-1:0] cache_idx_t;
    typedef logic [LOG_FETCH_PARA-1:0] word_idx_t;

    typedef enum logic {
        PF_RUN,
        PF_LOAD
    } pf_mode_t;

    // line address of a byte pc
    function automatic line_addr_t pc_line(word_t pc);
        return pc[LINE_LSB +: LEN_MEMISTR_ADDR];
    endfunction

    // word position inside its line
    function automatic word_idx_t word_sel(word_t pc);
        return pc[2 +: LOG_FETCH_PARA];
    endfunction

endpackage

/* hdl/cache_port_if.sv */
`timescale 1ns/1ns

// group of combinational cache lookup ports
interface cache_port_if #(
    parameter int NUM_PORTS = 1
);
    import fetch_pkg::*;

    logic [NUM_PORTS-1:0] req;
    line_addr_t           addr [NUM_PORTS];
    logic [NUM_PORTS-1:0] hit;
    cache_line_t          line [NUM_PORTS];

    modport client (
        output req,
        output addr,
        input  hit,
        input  line
    );

    modport cache (
        input  req,
        input  addr,
        output hit,
        output line
    );

endinterface

/* hdl/inflight_tracker.sv */
`timescale 1ns/1ns

module inflight_tracker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            issue,
    input  fetch_pkg::line_addr_t           issue_addr,
    output logic                            ret_valid,
    output fetch_pkg::line_addr_t           ret_addr,
    input  fetch_pkg::line_addr_t           probe_addr [fetch_pkg::NUM_PROBE],
    output logic [fetch_pkg::NUM_PROBE-1:0] in_flight
);
    import fetch_pkg::*;

    // stage 0 waits on the memory, stage 1 lines up with mem_rdata
    logic [1:0] stage_valid;
    line_addr_t stage_addr [2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[0], issue};
        end
    end

    always_ff @(posedge clk) begin
        stage_addr[0] <= issue_addr;
        stage_addr[1] <= stage_addr[0];
    end

    assign ret_valid = stage_valid[1];
    assign ret_addr  = stage_addr[1];

    // a probe is busy while any valid stage holds its line
    always_comb begin
        for (int p = 0; p < NUM_PROBE; p++) begin
            in_flight[p] = (issue && (issue_addr == probe_addr[p]))
                        || (stage_valid[0] && (stage_addr[0] == probe_addr[p]))
                        || (stage_valid[1] && (stage_addr[1] == probe_addr[p]));
        end
    end

endmodule

/* hdl/fetch_prefetcher.sv */
`timescale 1ns/1ns

module fetch_prefetcher (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fetch_pkg::line_addr_t  last_hit,
    input  logic                   miss,
    input  fetch_pkg::line_addr_t  miss_addr,
    input  fetch_pkg::word_t       lr,
    cache_port_if.client           probe_side,
    output logic                   fill_valid,
    output fetch_pkg::line_addr_t  fill_key,
    output fetch_pkg::cache_line_t fill_line,
    output logic                   mem_req,
    output fetch_pkg::line_addr_t  mem_addr,
    input  fetch_pkg::cache_line_t mem_rdata,
    output fetch_pkg::wen_t        mem_wen,
    output fetch_pkg::word_t       mem_wdata,
    input  logic                   prold_mode,
    input  logic                   prold_write,
    input  fetch_pkg::word_t       prold_pc,
    input  fetch_pkg::word_t       prold_data
);
    import fetch_pkg::*;

    pf_mode_t             mode;
    line_addr_t           base;
    line_addr_t           cand [NUM_PROBE];
    logic [NUM_PROBE-1:0] in_flight;
    logic [NUM_PROBE-1:0] needy;
    logic                 pick_valid;
    line_addr_t           pick_addr;
    logic                 ret_valid;
    line_addr_t           ret_addr;

    assign mode = prold_mode ? PF_LOAD : PF_RUN;

    // predict from the missed line, else from the last one that hit
    assign base = miss ? miss_addr : last_hit;

    // index 0 is base+4, last slot is the link register line
    always_comb begin
        for (int i = 0; i < PREDICT_SIZE; i++) begin
            cand[i] = base + line_addr_t'(PREDICT_SIZE - 1 - i);
        end
        cand[PREDICT_SIZE] = pc_line(lr);
    end

    assign probe_side.req  = '1;
    assign probe_side.addr = cand;

    assign needy = ~(probe_side.hit | in_flight);

    // lowest needy index wins
    always_comb begin
        pick_addr = cand[NUM_PROBE-1];
        for (int i = NUM_PROBE - 1; i >= 0; i--) begin
            if (needy[i]) begin
                pick_addr = cand[i];
            end
        end
    end

    assign pick_valid = (mode == PF_RUN) && (|needy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req <= 1'b0;
            mem_wen <= '0;
        end else begin
            mem_req <= pick_valid;
            if ((mode == PF_LOAD) && prold_write) begin
                mem_wen <= wen_t'(1) << word_sel(prold_pc);
            end else begin
                mem_wen <= '0;
            end
        end
    end

    // load mode steers the address to the word being written
    always_ff @(posedge clk) begin
        mem_addr  <= (mode == PF_LOAD) ? pc_line(prold_pc) : pick_addr;
        mem_wdata <= prold_data;
    end

    inflight_tracker u_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (mem_req),
        .issue_addr (mem_addr),
        .ret_valid  (ret_valid),
        .ret_addr   (ret_addr),
        .probe_addr (cand),
        .in_flight  (in_flight)
    );

    // read data goes straight to the cache
    assign fill_valid = ret_valid;
    assign fill_key   = ret_addr;
    assign fill_line  = mem_rdata;

endmodule

/* hdl/line_cache.sv */
`timescale 1ns/1ns

module line_cache (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fill_valid,
    input  fetch_pkg::line_addr_t  fill_key,
    input  fetch_pkg::cache_line_t fill_line,
    cache_port_if.cache            fetch_side,
    cache_port_if.cache            probe_side
);
    import fetch_pkg::*;

    logic [CACHE_DEPTH-1:0] valid;
    line_addr_t             tags  [CACHE_DEPTH];
    cache_line_t            lines [CACHE_DEPTH];
    cache_idx_t             victim;
    logic [CACHE_DEPTH-1:0] fill_match;
    cache_idx_t             match_idx;
    cache_idx_t             wr_idx;

    function automatic logic [CACHE_DEPTH-1:0] match_of(line_addr_t key);
        logic [CACHE_DEPTH-1:0] m;
        for (int e = 0; e < CACHE_DEPTH; e++) begin
            m[e] = valid[e] && (tags[e] == key);
        end
        return m;
    endfunction

    // at most one entry matches, so an OR is enough
    function automatic cache_line_t sel_line(logic [CACHE_DEPTH-1:0] m);
        cache_line_t l;
        l = '0;
        for (int e = 0; e < CACHE_DEPTH; e++) begin
            if (m[e]) begin
                l = l | lines[e];
            end
        end
        return l;
    endfunction

    // existing key is refreshed in place
    assign fill_match = match_of(fill_key);

    always_comb begin
        match_idx = '0;
        for (int e = 0; e < CACHE_DEPTH; e++) begin
            if (fill_match[e]) begin
                match_idx = cache_idx_t'(e);
            end
        end
    end

    assign wr_idx = (|fill_match) ? match_idx : victim;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= '0;
            victim <= '0;
        end else if (fill_valid) begin
            valid[wr_idx] <= 1'b1;
            if (!(|fill_match)) begin
                victim <= victim + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tags[wr_idx]  <= fill_key;
            lines[wr_idx] <= fill_line;
        end
    end

    // lookups, all combinational
    always_comb begin
        fetch_side.hit[0]  = fetch_side.req[0] && (|match_of(fetch_side.addr[0]));
        fetch_side.line[0] = sel_line(match_of(fetch_side.addr[0]));
    end

    always_comb begin
        for (int p = 0; p < NUM_PROBE; p++) begin
            probe_side.hit[p]  = probe_side.req[p] && (|match_of(probe_side.addr[p]));
            probe_side.line[p] = sel_line(match_of(probe_side.addr[p]));
        end
    end

endmodule

/* hdl/fetch_port.sv */
`timescale 1ns/1ns

module fetch_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  order,
    input  fetch_pkg::word_t      pc,
    output logic                  done,
    output fetch_pkg::inst_t      instr,
    cache_port_if.client          lookup,
    output fetch_pkg::line_addr_t last_hit,
    output logic                  miss,
    output fetch_pkg::line_addr_t miss_addr
);
    import fetch_pkg::*;

    line_addr_t line_addr;
    word_idx_t  word_idx;

    assign line_addr = pc_line(pc);
    assign word_idx  = word_sel(pc);

    assign lookup.req[0]  = order;
    assign lookup.addr[0] = line_addr;

    // hit already carries order
    assign done  = lookup.hit[0];
    assign instr = lookup.line[0][LEN_INST*word_idx +: LEN_INST];

    assign miss      = order && !lookup.hit[0];
    assign miss_addr = line_addr;

    // base line for the next prediction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_hit <= '0;
        end else if (done) begin
            last_hit <= line_addr;
        end
    end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   order,
    input  fetch_pkg::word_t       pc,
    output logic                   done,
    output fetch_pkg::inst_t       instr,
    input  fetch_pkg::word_t       lr,
    output logic                   mem_req,
    output fetch_pkg::line_addr_t  mem_addr,
    input  fetch_pkg::cache_line_t mem_rdata,
    output fetch_pkg::wen_t        mem_wen,
    output fetch_pkg::word_t       mem_wdata,
    input  logic                   prold_mode,
    input  logic                   prold_write,
    input  fetch_pkg::word_t       prold_pc,
    input  fetch_pkg::word_t       prold_data
);
    import fetch_pkg::*;

    logic        fill_valid;
    line_addr_t  fill_key;
    cache_line_t fill_line;
    line_addr_t  last_hit;
    logic        miss;
    line_addr_t  miss_addr;

    cache_port_if #(.NUM_PORTS(1))         fetch_bus ();
    cache_port_if #(.NUM_PORTS(NUM_PROBE)) probe_bus ();

    fetch_port u_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .order     (order),
        .pc        (pc),
        .done      (done),
        .instr     (instr),
        .lookup    (fetch_bus.client),
        .last_hit  (last_hit),
        .miss      (miss),
        .miss_addr (miss_addr)
    );

    line_cache u_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_valid (fill_valid),
        .fill_key   (fill_key),
        .fill_line  (fill_line),
        .fetch_side (fetch_bus.cache),
        .probe_side (probe_bus.cache)
    );

    fetch_prefetcher u_prefetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .last_hit    (last_hit),
        .miss        (miss),
        .miss_addr   (miss_addr),
        .lr          (lr),
        .probe_side  (probe_bus.client),
        .fill_valid  (fill_valid),
        .fill_key    (fill_key),
        .fill_line   (fill_line),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .mem_wen     (mem_wen),
        .mem_wdata   (mem_wdata),
        .prold_mode  (prold_mode),
        .prold_write (prold_write),
        .prold_pc    (prold_pc),
        .prold_data  (prold_data)
    );

endmodule

/* tb/fetch_checker.sv */
`timescale 1ns/1ns

module fetch_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  order,
    input logic                  done,
    input logic                  mem_req,
    input fetch_pkg::line_addr_t mem_addr,
    input fetch_pkg::wen_t       mem_wen,
    input fetch_pkg::word_t      mem_wdata,
    input logic                  prold_mode,
    input logic                  prold_write,
    input fetch_pkg::word_t      prold_pc,
    input fetch_pkg::word_t      prold_data
);
    import fetch_pkg::*;

    int   fail_count = 0;
    logic active;

    // high once the first order or load write has been seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (order || prold_write) begin
            active <= 1'b1;
        end
    end

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> !mem_req && (mem_wen == '0))
        else begin fail_count++; $error("memory access before any order or load"); end

    load_write: assert property (@(posedge clk) disable iff (!rst_n)
        prold_mode && prold_write |=>
            (mem_wen == (wen_t'(1) << $past(prold_pc[2 +: LOG_FETCH_PARA])))
            && (mem_wdata == $past(prold_data))
            && (mem_addr == $past(prold_pc[LINE_LSB +: LEN_MEMISTR_ADDR])))
        else begin fail_count++; $error("load write enable, data or line wrong"); end

    no_stray_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(prold_mode && prold_write) |=> (mem_wen == '0))
        else begin fail_count++; $error("memory write without a load write"); end

    load_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        prold_mode |=> !mem_req)
        else begin fail_count++; $error("memory read issued in load mode"); end

    done_needs_order: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> order)
        else begin fail_count++; $error("done raised without order"); end

    // a line is never read again while its earlier read is in flight
    no_dup_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> !($past(mem_req) && (mem_addr == $past(mem_addr)))
            && !($past(mem_req, 2) && (mem_addr == $past(mem_addr, 2))))
        else begin fail_count++; $error("duplicate memory read of one line"); end

endmodule

/* tb/tb_fetch_top.sv */
`timescale 1ns/1ns

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int NUM_LINES = 2 ** LEN_MEMISTR_ADDR;
    localparam int NUM_WORDS = NUM_LINES * FETCH_PARA;
    localparam int LINE_BYTES = FETCH_PARA * 4;
    localparam int SEQ_COUNT = 400;
    localparam int TRIALS = 16;
    // about twice what load, sequential, jump and lr phases take
    localparam int TIMEOUT_CYCLES = 6000;

    logic        clk, rst_n, order, done, mem_req, prold_mode, prold_write;
    word_t       pc, lr, mem_wdata, prold_pc, prold_data;
    inst_t       instr, expected_instr;
    line_addr_t  mem_addr, rd_addr;
    cache_line_t mem_rdata;
    wen_t        mem_wen;
    logic        rd_req;
    cache_line_t mem_line [NUM_LINES];
    word_t       shadow [NUM_WORDS];
    word_t       loaded_pcs [$];
    int          mismatch_count = 0;
    int          fetch_errors = 0;
    int          done_count = 0;
    int          cycle_count = 0;

    fetch_top UUT (.*);

    bind fetch_top fetch_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // two-cycle read latency, word-enabled writes
    always @(posedge clk) begin
        rd_req  <= mem_req;
        rd_addr <= mem_addr;
        if (rd_req) begin
            mem_rdata <= mem_line[rd_addr];
        end
        for (int k = 0; k < FETCH_PARA; k++) begin
            if (mem_wen[k]) begin
                mem_line[mem_addr][LEN_WORD*k +: LEN_WORD] <= mem_wdata;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && done) begin
            done_count++;
            expected_instr = shadow[word_index(pc)];
            assert (instr == expected_instr) else begin
                mismatch_count++;
                $display("MISMATCH time=%0t signal=instr expected=%h actual=%h",
                         $time, expected_instr, instr);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic word_t init_word(int unsigned idx);
        return 32'h3c5a_0000 ^ (idx * 32'h0001_0013);
    endfunction

    function automatic int unsigned word_index(word_t addr);
        return addr[2 +: LEN_MEMISTR_ADDR + LOG_FETCH_PARA];
    endfunction

    function automatic word_t wrap_pc(word_t addr);
        return addr & word_t'(NUM_WORDS * 4 - 1);
    endfunction

    function automatic word_t pick_loaded();
        return loaded_pcs[$urandom_range(loaded_pcs.size() - 1, 0)];
    endfunction

    task automatic load_program(int count);
        word_t w_pc;
        for (int i = 0; i < count; i++) begin
            w_pc = word_t'($urandom_range(NUM_WORDS - 1, 0)) << 2;
            @(negedge clk);
            prold_write = 1'b1;
            prold_pc    = w_pc;
            prold_data  = $urandom;
            shadow[word_index(w_pc)] = prold_data;
            loaded_pcs.push_back(w_pc);
        end
        @(negedge clk);
        prold_write = 1'b0;
        prold_mode  = 1'b0;
    endtask

    task automatic fetch_word(word_t addr, int limit, string what);
        bit ok;
        @(negedge clk);
        order = 1'b1;
        pc    = addr;
        ok    = 1'b0;
        for (int i = 0; i < limit && !ok; i++) begin
            @(posedge clk);
            ok = done;
        end
        if (!ok) begin
            fetch_errors++;
            $display("%s: pc %h got no done within %0d cycles", what, addr, limit);
        end
    endtask

    // settled once mem_req has stayed low for a few cycles
    task automatic wait_prefetch_idle();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 4 && waited < 64) begin
            @(posedge clk);
            quiet = mem_req ? 0 : quiet + 1;
            waited++;
        end
        if (quiet < 4) begin
            fetch_errors++;
            $display("prefetch still busy after 64 cycles at %0t", $time);
        end
    endtask

    initial begin
        word_t target;
        void'($urandom(46));
        {order, prold_write, rst_n} = 3'b000;
        prold_mode = 1'b1;
        {pc, lr, prold_pc, prold_data} = '0;
        mem_rdata = '0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            shadow[i] = init_word(i);
        end
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int k = 0; k < FETCH_PARA; k++) begin
                mem_line[l][LEN_WORD*k +: LEN_WORD] = init_word(l * FETCH_PARA + k);
            end
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (20) @(negedge clk);
        load_program(256);
        target = pick_loaded();
        for (int i = 0; i < SEQ_COUNT; i++) begin
            fetch_word(wrap_pc(target + 4 * i), 20, "sequential fetch");
        end
        // the following lines are made resident so only the target misses
        for (int t = 0; t < TRIALS; t++) begin
            target = pick_loaded();
            fetch_word(wrap_pc(target + LINE_BYTES), 30, "warm-up fetch");
            wait_prefetch_idle();
            fetch_word(target, 6, "miss recovery");
        end
        for (int t = 0; t < TRIALS; t++) begin
            target = pick_loaded();
            @(negedge clk);
            lr = target;
            wait_prefetch_idle();
            fetch_word(target, 6, "link register prefetch");
        end
        @(negedge clk);
        order = 1'b0;
        repeat (4) @(negedge clk);
        if (done_count == 0) begin
            fetch_errors++;
            $display("no fetch completed during the run");
        end
        $display("errors: mismatch=%0d fetch=%0d assertion=%0d",
                 mismatch_count, fetch_errors, UUT.u_checker.fail_count);
        if (mismatch_count + fetch_errors + UUT.u_checker.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* fetch_top.f */
hdl/fetch_pkg.sv
hdl/cache_port_if.sv
hdl/inflight_tracker.sv
hdl/fetch_prefetcher.sv
hdl/line_cache.sv
hdl/fetch_port.sv
hdl/fetch_top.sv
tb/fetch_checker.sv
tb/tb_fetch_top.sv
